//--- verilog/rv_decode_pkg.sv
package rv_decode_pkg;

    // data path width, one machine word
    localparam int xlen = 32;

    // register specifier width in the instruction word
    localparam int reg_addr_w = 5;

    // instruction field widths
    localparam int opcode_w = 7;
    localparam int funct3_w = 3;
    localparam int funct7_w = 7;

    // rv32i major opcodes, architectural encodings
    typedef enum logic [opcode_w-1:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    // source of the value that writeback stores into rd
    typedef enum logic [1:0] {
        // alu result
        wb_alu = 2'd0,
        // load data from memory
        wb_mem = 2'd1,
        // return address for jal and jalr
        wb_pc4 = 2'd2
    } wb_sel_t;

    // opcode of a bubble, with zero fields this is addi x0,x0,0
    localparam opcode_t bubble_op = op_imm;

endpackage

//--- verilog/imm_gen.sv
module imm_gen import rv_decode_pkg::*; (
    input  logic [xlen-1:0]        instruction,
    output logic signed [xlen-1:0] imm
);

    // format is chosen from the major opcode
    opcode_t opcode;

    assign opcode = opcode_t'(instruction[opcode_w-1:0]);

    // every format sign-extends from instruction bit 31
    always_comb begin
        case (opcode)
            // i-type, imm[11:0] in bits 31:20
            op_imm, op_load, op_jalr: begin
                imm = {{20{instruction[31]}}, instruction[31:20]};
            end
            // s-type, split between funct7 and rd positions
            op_store: begin
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            // b-type, halfword offset so bit 0 is zero
            op_branch: begin
                imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            // u-type, upper 20 bits with the low 12 cleared
            op_lui, op_auipc: begin
                imm = {instruction[31:12], 12'b0};
            end
            // j-type, 21-bit halfword offset
            op_jal: begin
                imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            // csr, fence, ecall and anything unknown carry no immediate
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- verilog/control_unit.sv
module control_unit import rv_decode_pkg::*; (
    input  opcode_t opcode,
    // alu operand a from pc instead of rs1
    output logic    pc_rs1_sel,
    // alu operand b from the immediate instead of rs2
    output logic    imm_rs2_sel,
    // jump target from rs1 plus immediate
    output logic    jump_branch_sel,
    output logic    mem_wr_en,
    output logic    reg_wr_en,
    output wb_sel_t wb_sel,
    // source register usage, for the load-use check
    output logic    rs1_used,
    output logic    rs2_used
);

    always_comb begin
        // unsupported opcodes decode like a bubble, nothing written
        pc_rs1_sel      = 1'b0;
        imm_rs2_sel     = 1'b0;
        jump_branch_sel = 1'b0;
        mem_wr_en       = 1'b0;
        reg_wr_en       = 1'b0;
        wb_sel          = wb_alu;
        rs1_used        = 1'b0;
        rs2_used        = 1'b0;

        case (opcode)
            op_lui: begin
                imm_rs2_sel = 1'b1;
                reg_wr_en   = 1'b1;
            end
            // pc + upper immediate
            op_auipc: begin
                pc_rs1_sel  = 1'b1;
                imm_rs2_sel = 1'b1;
                reg_wr_en   = 1'b1;
            end
            // pc-relative jump, rd gets pc+4
            op_jal: begin
                pc_rs1_sel  = 1'b1;
                imm_rs2_sel = 1'b1;
                reg_wr_en   = 1'b1;
                wb_sel      = wb_pc4;
            end
            // register-indirect jump
            op_jalr: begin
                imm_rs2_sel     = 1'b1;
                jump_branch_sel = 1'b1;
                reg_wr_en       = 1'b1;
                wb_sel          = wb_pc4;
                rs1_used        = 1'b1;
            end
            // alu compares rs1 with rs2
            op_branch: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            op_load: begin
                imm_rs2_sel = 1'b1;
                reg_wr_en   = 1'b1;
                wb_sel      = wb_mem;
                rs1_used    = 1'b1;
            end
            // address from rs1 + imm, data from rs2
            op_store: begin
                imm_rs2_sel = 1'b1;
                mem_wr_en   = 1'b1;
                rs1_used    = 1'b1;
                rs2_used    = 1'b1;
            end
            op_imm: begin
                imm_rs2_sel = 1'b1;
                reg_wr_en   = 1'b1;
                rs1_used    = 1'b1;
            end
            op_reg: begin
                reg_wr_en = 1'b1;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
            end
            default: begin
                reg_wr_en = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/register_file.sv
module register_file import rv_decode_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] wr_addr,
    input  logic [xlen-1:0]       wr_data,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    localparam int idx_w = $clog2(num_regs);

    // with 16 registers the top address bit drops out here
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rs1_idx;
    logic [idx_w-1:0] rs2_idx;
    logic [xlen-1:0]  regs [num_regs];

    assign wr_idx  = wr_addr[idx_w-1:0];
    assign rs1_idx = rs1_addr[idx_w-1:0];
    assign rs2_idx = rs2_addr[idx_w-1:0];

    // entry 0 is never written so x0 stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // writeback in the same cycle is forwarded to a matching read
    always_comb begin
        if (rs1_idx == '0) begin
            rs1_data = '0;
        end else if (wr_en && (wr_idx == rs1_idx)) begin
            rs1_data = wr_data;
        end else begin
            rs1_data = regs[rs1_idx];
        end

        if (rs2_idx == '0) begin
            rs2_data = '0;
        end else if (wr_en && (wr_idx == rs2_idx)) begin
            rs2_data = wr_data;
        end else begin
            rs2_data = regs[rs2_idx];
        end
    end

endmodule

//--- verilog/hazard_unit.sv
module hazard_unit import rv_decode_pkg::*; (
    // load now in ex, identified by its writeback source
    input  wb_sel_t               wb_sel_idex,
    input  logic [reg_addr_w-1:0] rd_idex,
    // sources of the instruction in id
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic                  rs1_used,
    input  logic                  rs2_used,
    output logic                  stall
);

    logic load_in_ex;
    logic rs1_hit;
    logic rs2_hit;

    // a load into x0 never produces a dependency
    assign load_in_ex = (wb_sel_idex == wb_mem) && (rd_idex != '0);

    // only sources that the instruction really reads count
    assign rs1_hit = rs1_used && (rs1 == rd_idex);
    assign rs2_hit = rs2_used && (rs2 == rd_idex);

    // load data arrives too late to forward, hold id for one cycle
    assign stall = load_in_ex && (rs1_hit || rs2_hit);

endmodule

//--- verilog/instruction_decode.sv
module instruction_decode import rv_decode_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    // from if/id
    input  logic [xlen-1:0]        instruction_ifid,
    input  logic [xlen-1:0]        pc_ifid,
    input  logic [xlen-1:0]        pc_4_ifid,
    // register file write from writeback
    input  logic [xlen-1:0]        reg_wr_data_wbid,
    input  logic [reg_addr_w-1:0]  rd_wbid,
    input  logic                   reg_wr_en_wbid,
    // taken branch or jump resolved in ex
    input  logic                   flush_exif,
    // ex stage
    output opcode_t                op_idex,
    output logic [funct3_w-1:0]    funct3_idex,
    output logic [funct7_w-1:0]    funct7_idex,
    output logic [xlen-1:0]        rs1_data_idex,
    output logic [xlen-1:0]        rs2_data_idex,
    output logic signed [xlen-1:0] immediate_idex,
    output logic [xlen-1:0]        pc_idex,
    output logic [xlen-1:0]        pc_4_idex,
    output logic                   jump_branch_sel_idex,
    // mem stage
    output logic                   mem_wr_en_idex,
    // wb stage
    output logic                   reg_wr_en_idex,
    output wb_sel_t                wb_sel_idex,
    output logic [reg_addr_w-1:0]  rd_idex,
    // forwarding unit
    output logic [reg_addr_w-1:0]  rs1_idex,
    output logic [reg_addr_w-1:0]  rs2_idex,
    output logic                   pc_rs1_sel_idex,
    output logic                   imm_rs2_sel_idex,
    // to fetch, hold pc and if/id
    output logic                   stall
);

    // fields of the instruction in id
    opcode_t                opcode;
    logic [funct3_w-1:0]    funct3;
    logic [funct7_w-1:0]    funct7;
    logic [reg_addr_w-1:0]  rs1;
    logic [reg_addr_w-1:0]  rs2;
    logic [reg_addr_w-1:0]  rd;

    // decode results
    logic signed [xlen-1:0] immediate;
    logic [xlen-1:0]        rs1_data;
    logic [xlen-1:0]        rs2_data;
    logic                   pc_rs1_sel;
    logic                   imm_rs2_sel;
    logic                   jump_branch_sel;
    logic                   mem_wr_en;
    logic                   reg_wr_en;
    wb_sel_t                wb_sel;
    logic                   rs1_used;
    logic                   rs2_used;

    // standard rv32i field positions
    assign opcode = opcode_t'(instruction_ifid[opcode_w-1:0]);
    assign rd     = instruction_ifid[11:7];
    assign funct3 = instruction_ifid[14:12];
    assign rs1    = instruction_ifid[19:15];
    assign rs2    = instruction_ifid[24:20];
    assign funct7 = instruction_ifid[31:25];

    imm_gen imm_gen0 (
        .instruction (instruction_ifid),
        .imm         (immediate)
    );

    control_unit control_unit0 (
        .opcode          (opcode),
        .pc_rs1_sel      (pc_rs1_sel),
        .imm_rs2_sel     (imm_rs2_sel),
        .jump_branch_sel (jump_branch_sel),
        .mem_wr_en       (mem_wr_en),
        .reg_wr_en       (reg_wr_en),
        .wb_sel          (wb_sel),
        .rs1_used        (rs1_used),
        .rs2_used        (rs2_used)
    );

    register_file #(
        .num_regs (num_regs)
    ) register_file0 (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (reg_wr_en_wbid),
        .wr_addr  (rd_wbid),
        .wr_data  (reg_wr_data_wbid),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // compares id sources against the registered ex destination
    hazard_unit hazard_unit0 (
        .wb_sel_idex (wb_sel_idex),
        .rd_idex     (rd_idex),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_used    (rs1_used),
        .rs2_used    (rs2_used),
        .stall       (stall)
    );

    // id/ex register
    always_ff @(posedge clk) begin
        if (rst || flush_exif || stall) begin
            // bubble is addi x0,x0,0 with every control inactive
            op_idex              <= bubble_op;
            funct3_idex          <= '0;
            funct7_idex          <= '0;
            rs1_data_idex        <= '0;
            rs2_data_idex        <= '0;
            immediate_idex       <= '0;
            pc_idex              <= '0;
            pc_4_idex            <= '0;
            jump_branch_sel_idex <= 1'b0;
            mem_wr_en_idex       <= 1'b0;
            reg_wr_en_idex       <= 1'b0;
            wb_sel_idex          <= wb_alu;
            rd_idex              <= '0;
            rs1_idex             <= '0;
            rs2_idex             <= '0;
            pc_rs1_sel_idex      <= 1'b0;
            imm_rs2_sel_idex     <= 1'b0;
        end else begin
            op_idex              <= opcode;
            funct3_idex          <= funct3;
            funct7_idex          <= funct7;
            rs1_data_idex        <= rs1_data;
            rs2_data_idex        <= rs2_data;
            immediate_idex       <= immediate;
            pc_idex              <= pc_ifid;
            pc_4_idex            <= pc_4_ifid;
            jump_branch_sel_idex <= jump_branch_sel;
            mem_wr_en_idex       <= mem_wr_en;
            reg_wr_en_idex       <= reg_wr_en;
            wb_sel_idex          <= wb_sel;
            rd_idex              <= rd;
            // source specifiers go on for the forwarding unit
            rs1_idex             <= rs1;
            rs2_idex             <= rs2;
            pc_rs1_sel_idex      <= pc_rs1_sel;
            imm_rs2_sel_idex     <= imm_rs2_sel;
        end
    end

endmodule

//--- tb/instruction_decode_sva.sv
module instruction_decode_sva import rv_decode_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic [xlen-1:0]        instruction_ifid,
    input logic [xlen-1:0]        pc_ifid,
    input logic [xlen-1:0]        pc_4_ifid,
    input logic [xlen-1:0]        reg_wr_data_wbid,
    input logic [reg_addr_w-1:0]  rd_wbid,
    input logic                   reg_wr_en_wbid,
    input logic                   flush_exif,
    input logic                   stall,
    input opcode_t                op_idex,
    input logic [funct3_w-1:0]    funct3_idex,
    input logic [funct7_w-1:0]    funct7_idex,
    input logic [xlen-1:0]        rs1_data_idex,
    input logic [xlen-1:0]        rs2_data_idex,
    input logic signed [xlen-1:0] immediate_idex,
    input logic [xlen-1:0]        pc_idex,
    input logic [xlen-1:0]        pc_4_idex,
    input logic                   jump_branch_sel_idex,
    input logic                   mem_wr_en_idex,
    input logic                   reg_wr_en_idex,
    input wb_sel_t                wb_sel_idex,
    input logic [reg_addr_w-1:0]  rd_idex,
    input logic [reg_addr_w-1:0]  rs1_idex,
    input logic [reg_addr_w-1:0]  rs2_idex,
    input logic                   pc_rs1_sel_idex,
    input logic                   imm_rs2_sel_idex
);

    // architectural registers as seen through the writeback port
    logic [xlen-1:0] shadow [32];
    logic            seen_rst = 1'b0;
    // inputs of the previous cycle
    logic            p_gate;
    logic [xlen-1:0] p_ins, p_pc, p_pc4, p_rs1, p_rs2;
    logic [6:0]      p_op, c_op;
    // expected decode of the previous instruction
    logic [xlen-1:0] e_imm;
    logic            e_wr, e_mem, e_jalr, e_pc_sel, e_imm_sel, e_stall;
    wb_sel_t         e_wb;
    int unsigned     fail_count = 0;

    // x0 reads zero and a same-cycle write is already visible
    function automatic logic [xlen-1:0] read_reg(input logic [4:0] a);
        if (a == 5'd0) begin
            return '0;
        end
        if (reg_wr_en_wbid && rd_wbid == a) begin
            return reg_wr_data_wbid;
        end
        return shadow[a];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            seen_rst <= 1'b1;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (reg_wr_en_wbid && rd_wbid != '0) begin
            shadow[rd_wbid] <= reg_wr_data_wbid;
        end
        // a bubble is due after any of these
        p_gate <= rst || flush_exif || stall;
        p_ins  <= instruction_ifid;
        p_pc   <= pc_ifid;
        p_pc4  <= pc_4_ifid;
        p_rs1  <= read_reg(instruction_ifid[19:15]);
        p_rs2  <= read_reg(instruction_ifid[24:20]);
    end

    assign p_op = p_ins[6:0];
    assign c_op = instruction_ifid[6:0];

    always_comb begin
        // immediate formats take the sign from bit 31
        case (p_op)
            op_imm, op_load, op_jalr: e_imm = $signed(p_ins) >>> 20;
            op_store:  e_imm = {{21{p_ins[31]}}, p_ins[30:25], p_ins[11:7]};
            op_branch: e_imm = {{20{p_ins[31]}}, p_ins[7], p_ins[30:25], p_ins[11:8], 1'b0};
            op_lui, op_auipc: e_imm = {p_ins[31:12], 12'h000};
            op_jal:    e_imm = {{12{p_ins[31]}}, p_ins[19:12], p_ins[20], p_ins[30:21], 1'b0};
            default:   e_imm = '0;
        endcase
        // decode table
        e_wr      = p_op inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg};
        e_mem     = (p_op == op_store);
        e_jalr    = (p_op == op_jalr);
        e_pc_sel  = p_op inside {op_auipc, op_jal};
        e_imm_sel = p_op inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_store, op_imm};
        if (p_op == op_load) begin
            e_wb = wb_mem;
        end else if (p_op inside {op_jal, op_jalr}) begin
            e_wb = wb_pc4;
        end else begin
            e_wb = wb_alu;
        end
        // load in ex whose rd is read by the instruction in id
        e_stall = (wb_sel_idex == wb_mem) && (rd_idex != '0) &&
                  ((c_op inside {op_jalr, op_branch, op_load, op_store, op_imm, op_reg} &&
                    instruction_ifid[19:15] == rd_idex) ||
                   (c_op inside {op_branch, op_store, op_reg} &&
                    instruction_ifid[24:20] == rd_idex));
    end

    a_bubble: assert property (@(posedge clk) seen_rst && p_gate |->
        op_idex == bubble_op && !reg_wr_en_idex && !mem_wr_en_idex && rd_idex == '0)
        else begin
            fail_count++;
            $error("error %0t: id/ex did not load a bubble", $time);
        end

    // operands and pc values of the previous instruction
    a_operands: assert property (@(posedge clk) seen_rst && !p_gate |->
        rs1_data_idex == p_rs1 && rs2_data_idex == p_rs2 && pc_idex == p_pc && pc_4_idex == p_pc4)
        else begin
            fail_count++;
            $error("error %0t: operand or pc mismatch in id/ex", $time);
        end

    a_immediate: assert property (@(posedge clk) seen_rst && !p_gate |-> immediate_idex == e_imm)
        else begin
            fail_count++;
            $error("error %0t: immediate %h, expected %h", $time, immediate_idex, e_imm);
        end

    // instruction fields pass through unchanged next to the decoded controls
    a_control: assert property (@(posedge clk) seen_rst && !p_gate |->
        op_idex == p_op && rd_idex == p_ins[11:7] && reg_wr_en_idex == e_wr &&
        funct3_idex == p_ins[14:12] && funct7_idex == p_ins[31:25] &&
        rs1_idex == p_ins[19:15] && rs2_idex == p_ins[24:20] &&
        mem_wr_en_idex == e_mem && wb_sel_idex == e_wb && jump_branch_sel_idex == e_jalr &&
        pc_rs1_sel_idex == e_pc_sel && imm_rs2_sel_idex == e_imm_sel)
        else begin
            fail_count++;
            $error("error %0t: control mismatch for opcode %h", $time, p_op);
        end

    // stall is combinational and is checked every cycle
    a_stall: assert property (@(posedge clk) seen_rst |-> stall == e_stall)
        else begin
            fail_count++;
            $error("error %0t: stall is %b, expected %b", $time, stall, e_stall);
        end

endmodule

// checker sits inside the decode stage
bind instruction_decode instruction_decode_sva sva0 (.*);

//--- tb/instruction_decode_tb.sv
module instruction_decode_tb import rv_decode_pkg::*; ();

    logic clk = 1'b0;
    logic rst;
    // fetch and writeback side, played by the testbench
    logic [31:0]        instruction_ifid, pc_ifid, pc_4_ifid;
    logic [31:0]        reg_wr_data_wbid;
    logic [4:0]         rd_wbid;
    logic               reg_wr_en_wbid;
    logic               flush_exif;
    // id/ex outputs
    opcode_t            op_idex;
    logic [2:0]         funct3_idex;
    logic [6:0]         funct7_idex;
    logic [31:0]        rs1_data_idex, rs2_data_idex, pc_idex, pc_4_idex;
    logic signed [31:0] immediate_idex;
    logic               jump_branch_sel_idex, mem_wr_en_idex, reg_wr_en_idex;
    wb_sel_t            wb_sel_idex;
    logic [4:0]         rd_idex, rs1_idex, rs2_idex;
    logic               pc_rs1_sel_idex, imm_rs2_sel_idex;
    logic               stall;

    logic [31:0] pc;
    int          timeouts = 0;
    // nine rv32i opcodes, then fence which decodes with no write enables
    logic [6:0]  ops [10] = '{op_lui, op_auipc, op_jal, op_jalr, op_branch,
                              op_load, op_store, op_imm, op_reg, 7'b0001111};

    instruction_decode #(.num_regs(32)) dut0 (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // wait for the edge, then drop the one-cycle strobes
    task automatic next_cycle();
        @(posedge clk);
        #1;
        reg_wr_en_wbid = 1'b0;
        flush_exif     = 1'b0;
    endtask

    task automatic write_back(input logic [4:0] rd, input logic [31:0] data);
        reg_wr_en_wbid   = 1'b1;
        rd_wbid          = rd;
        reg_wr_data_wbid = data;
    endtask

    // present an instruction, hold it while stall is high
    task automatic issue(input logic [31:0] ins);
        int waited;
        waited = 0;
        instruction_ifid = ins;
        pc_ifid          = pc;
        pc_4_ifid        = pc + 32'd4;
        #1;
        while (stall) begin
            if (waited == 20) begin
                timeouts++;
                $display("timeout at %0t: stall still high after 20 cycles", $time);
                break;
            end
            waited++;
            next_cycle();
            #1;
        end
        next_cycle();
        pc = pc + 32'd4;
    endtask

    initial begin
        logic [31:0] ins;
        void'($urandom(32'h3ca1));
        rst              = 1'b1;
        instruction_ifid = 32'h0000_0013;
        pc_ifid          = '0;
        pc_4_ifid        = '0;
        reg_wr_data_wbid = '0;
        rd_wbid          = '0;
        reg_wr_en_wbid   = 1'b0;
        flush_exif       = 1'b0;
        pc               = 32'h0000_1000;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // preload x1..x7 while decode sees addi x0,x0,0
        for (int i = 1; i < 8; i++) begin
            write_back(5'(i), 32'h1000_0000 + 32'(i) * 32'h0101_0101);
            issue(32'h0000_0013);
        end
        // one of each opcode, funct7 msb set so immediates are negative
        for (int k = 0; k < 10; k++) begin
            issue(encode(7'h41 + 7'(k), 5'd2, 5'd1, 3'(k), 5'(8 + k), ops[k]));
        end
        // x1 read in the same cycle that writeback updates it
        write_back(5'd1, 32'hcafe_0001);
        issue(encode(7'h00, 5'd1, 5'd1, 3'd0, 5'd20, op_reg));
        // lw x10 then add x11,x10,x2
        issue(encode(7'h00, 5'd0, 5'd1, 3'd2, 5'd10, op_load));
        issue(encode(7'h00, 5'd2, 5'd10, 3'd0, 5'd11, op_reg));
        // lw x10 then addi x12,x10,1
        issue(encode(7'h00, 5'd0, 5'd1, 3'd2, 5'd10, op_load));
        issue(encode(7'h00, 5'd1, 5'd10, 3'd0, 5'd12, op_imm));
        // taken branch squashes this decode
        flush_exif = 1'b1;
        issue(encode(7'h00, 5'd3, 5'd4, 3'd0, 5'd13, op_reg));

        for (int n = 0; n < 400; n++) begin
            if ($urandom % 3 == 0) begin
                write_back(5'($urandom), $urandom);
            end
            flush_exif = ($urandom % 16 == 0);
            ins        = $urandom;
            ins[6:0]   = ops[$urandom % 10];
            // few registers in use so load-use pairs come up often
            ins[11:7]  = 5'($urandom % 8);
            ins[19:15] = 5'($urandom % 8);
            ins[24:20] = 5'($urandom % 8);
            issue(ins);
        end
        repeat (2) @(posedge clk);
        #1;

        $display("assertion failures: %0d, timeouts: %0d", dut0.sva0.fail_count, timeouts);
        if (dut0.sva0.fail_count == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
verilog/rv_decode_pkg.sv
verilog/imm_gen.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/hazard_unit.sv
verilog/instruction_decode.sv
tb/instruction_decode_sva.sv
tb/instruction_decode_tb.sv
